// ==== fftCore.f ====
+incdir+logic
logic/fftDataPkg.sv
logic/fftCtrlPkg.sv
logic/fftControl.sv
logic/fftStepCounter.sv
logic/sampleRam.sv
logic/butterflyUnit.sv
logic/outBuffer.sv
logic/fftCore.sv
test/fftCoreTb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it and check sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -Wno-fatal -f fftCore.f --top-module fftCoreTb -Mdir obj_dir
	./obj_dir/VfftCoreTb | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== test/fftCoreTb.sv ====
`include "fft_consts.svh"

module fftCoreTb;

    localparam int TimeoutCycles = 200;

    logic                clk = 1'b0;
    logic                rst;
    logic                startF;
    logic                startI;
    logic                startLoadingRam;
    logic                inValid;
    fftDataPkg::sample_t inRe;
    fftDataPkg::sample_t inIm;
    logic                outRead;
    fftDataPkg::sample_t outRe;
    fftDataPkg::sample_t outIm;
    logic                outValid;
    logic                calculating;
    logic                aDone;
    logic                isIFFT;

    int seed;
    int inverseCycles = 0;
    int inverseBase;
    int sRe   [2][`FFT_POINTS];
    int sIm   [2][`FFT_POINTS];
    int expRe [2][`FFT_POINTS];
    int expIm [2][`FFT_POINTS];

    fftCore i_fftCore (
        .clk             (clk),
        .rst             (rst),
        .startF          (startF),
        .startI          (startI),
        .startLoadingRam (startLoadingRam),
        .inValid         (inValid),
        .inRe            (inRe),
        .inIm            (inIm),
        .outRead         (outRead),
        .outRe           (outRe),
        .outIm           (outIm),
        .outValid        (outValid),
        .calculating     (calculating),
        .aDone           (aDone),
        .isIFFT          (isIFFT)
    );

    always #10 clk = ~clk;

    // Cycles spent in inverse calculation
    always @(negedge clk) begin
        if (isIFFT) begin
            inverseCycles <= inverseCycles + 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reporting
    //////////////////////////////////////////////////////////////////////
    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic checkValue(input string testName, input int expected, input int actual);
        if (expected != actual) begin
            stopWithFailure($sformatf("ERR %s: expected %0d, actual %0d",
                                      testName, expected, actual));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus and reference model
    //////////////////////////////////////////////////////////////////////
    task automatic fillRandom(input int setIdx);
        int r;
        for (int n = 0; n < `FFT_POINTS; n++) begin
            // Signed 12-bit values
            r = $random(seed);
            sRe[setIdx][n] = (r <<< 20) >>> 20;
            r = $random(seed);
            sIm[setIdx][n] = (r <<< 20) >>> 20;
        end
    endtask

    // Unscaled direct DFT with a negative exponent for forward and a positive one for inverse
    task automatic computeDft(input int setIdx, input logic inverse);
        int accRe;
        int accIm;
        int tr;
        int ti;
        int tmp;
        for (int k = 0; k < `FFT_POINTS; k++) begin
            accRe = 0;
            accIm = 0;
            for (int n = 0; n < `FFT_POINTS; n++) begin
                tr = sRe[setIdx][n];
                ti = sIm[setIdx][n];
                // Quarter turns of the twiddle
                repeat ((n * k) % `FFT_POINTS) begin
                    tmp = tr;
                    if (inverse) begin
                        tr = -ti;
                        ti = tmp;
                    end else begin
                        tr = ti;
                        ti = -tmp;
                    end
                end
                accRe += tr;
                accIm += ti;
            end
            expRe[setIdx][k] = accRe;
            expIm[setIdx][k] = accIm;
        end
    endtask

    task automatic startTransform(input logic fwd, input logic inv);
        @(posedge clk);
        startF <= fwd;
        startI <= inv;
        inverseBase = inverseCycles;
        @(posedge clk);
        startF          <= 1'b0;
        startI          <= 1'b0;
        startLoadingRam <= 1'b1;
    endtask

    task automatic feedSamples(input int setIdx, input int maxGap);
        int gap;
        for (int n = 0; n < `FFT_POINTS; n++) begin
            gap = $unsigned($random(seed)) % (maxGap + 1);
            repeat (gap) begin
                @(posedge clk);
                inValid <= 1'b0;
            end
            @(posedge clk);
            inValid <= 1'b1;
            inRe    <= fftDataPkg::sample_t'(sRe[setIdx][n]);
            inIm    <= fftDataPkg::sample_t'(sIm[setIdx][n]);
        end
        @(posedge clk);
        inValid         <= 1'b0;
        startLoadingRam <= 1'b0;
    endtask

    task automatic waitForDone(input string name);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!aDone && waited < TimeoutCycles) begin
            @(negedge clk);
            waited++;
        end
        if (!aDone) begin
            stopWithFailure($sformatf("%s: timed out waiting for aDone", name));
        end else begin
            // DONE lasts a single cycle
            @(negedge clk);
            checkValue({name, " aDone pulse"}, 0, int'(aDone));
        end
    endtask

    task automatic popResults(input string name, input int setIdx);
        int waited;
        for (int k = 0; k < `FFT_POINTS; k++) begin
            waited = 0;
            @(negedge clk);
            while (!outValid && waited < TimeoutCycles) begin
                @(negedge clk);
                waited++;
            end
            if (!outValid) begin
                stopWithFailure($sformatf("%s: result %0d never reached the output buffer",
                                          name, k));
            end else begin
                checkValue($sformatf("%s re[%0d]", name, k), expRe[setIdx][k], int'(outRe));
                checkValue($sformatf("%s im[%0d]", name, k), expIm[setIdx][k], int'(outIm));
                @(posedge clk);
                outRead <= 1'b1;
                @(posedge clk);
                outRead <= 1'b0;
            end
        end
        @(negedge clk);
        checkValue({name, " buffer empty"}, 0, int'(outValid));
    endtask

    task automatic runTransform(input string name, input int setIdx, input logic fwd,
                                input logic inv, input logic expectInverse, input int maxGap);
        computeDft(setIdx, expectInverse);
        startTransform(fwd, inv);
        feedSamples(setIdx, maxGap);
        waitForDone(name);
        // One inverse cycle per butterfly
        checkValue({name, " isIFFT cycles"}, expectInverse ? `FFT_POINTS : 0,
                   inverseCycles - inverseBase);
        popResults(name, setIdx);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////
    task automatic checkResetState;
        @(negedge clk);
        checkValue("reset outValid", 0, int'(outValid));
        checkValue("reset aDone", 0, int'(aDone));
        checkValue("reset calculating", 0, int'(calculating));
    endtask

    task automatic testImpulse;
        for (int n = 0; n < `FFT_POINTS; n++) begin
            sRe[0][n] = 0;
            sIm[0][n] = 0;
        end
        sRe[0][0] = 1000;
        sIm[0][0] = -500;
        runTransform("impulse", 0, 1'b1, 1'b0, 1'b0, 0);
    endtask

    task automatic testBackPressure;
        fillRandom(0);
        fillRandom(1);
        computeDft(0, 1'b0);
        computeDft(1, 1'b0);
        startTransform(1'b1, 1'b0);
        feedSamples(0, 0);
        waitForDone("backpressure first");
        checkValue("backpressure first isIFFT cycles", 0, inverseCycles - inverseBase);
        startTransform(1'b1, 1'b0);
        feedSamples(1, 1);
        // Second run has to stall in LOADOUT
        for (int i = 0; i < 40; i++) begin
            @(negedge clk);
            if (aDone) begin
                stopWithFailure("second aDone came while the first results were unread");
            end
        end
        checkValue("backpressure results held", 1, int'(outValid));
        checkValue("backpressure still busy", 1, int'(calculating));
        popResults("backpressure first", 0);
        waitForDone("backpressure second");
        checkValue("backpressure second isIFFT cycles", 0, inverseCycles - inverseBase);
        popResults("backpressure second", 1);
    endtask

    initial begin
        seed            = 32'ha1d4;
        rst             = 1'b1;
        startF          = 1'b0;
        startI          = 1'b0;
        startLoadingRam = 1'b0;
        inValid         = 1'b0;
        inRe            = '0;
        inIm            = '0;
        outRead         = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        checkResetState();
        testImpulse();
        fillRandom(0);
        runTransform("forward random", 0, 1'b1, 1'b0, 1'b0, 0);
        fillRandom(1);
        runTransform("inverse random", 1, 1'b0, 1'b1, 1'b1, 0);
        fillRandom(0);
        runTransform("forward gaps", 0, 1'b1, 1'b0, 1'b0, 3);
        fillRandom(1);
        runTransform("inverse gaps", 1, 1'b0, 1'b1, 1'b1, 3);
        testBackPressure();
        // Forward wins over inverse
        fillRandom(0);
        runTransform("both starts", 0, 1'b1, 1'b1, 1'b0, 0);

        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== logic/fftCore.sv ====
module fftCore (
    input  logic                clk,
    input  logic                rst,
    input  logic                startF,
    input  logic                startI,
    input  logic                startLoadingRam,
    input  logic                inValid,
    input  fftDataPkg::sample_t inRe,
    input  fftDataPkg::sample_t inIm,
    input  logic                outRead,
    output fftDataPkg::sample_t outRe,
    output fftDataPkg::sample_t outIm,
    output logic                outValid,
    output logic                calculating,
    output logic                aDone,
    output logic                isIFFT
);

    fftCtrlPkg::countMode_t countMode;
    logic                   loadExternal;
    logic                   loadInternal;
    logic                   loadOutBuffer;
    logic                   loadExternalDone;
    logic                   done;
    logic                   outLoadDone;
    logic                   outFifoReady;
    logic                   useTwiddle;
    fftDataPkg::addr_t      step;
    fftDataPkg::sample_t    aRe;
    fftDataPkg::sample_t    aIm;
    fftDataPkg::sample_t    bRe;
    fftDataPkg::sample_t    bIm;
    fftDataPkg::sample_t    sumRe;
    fftDataPkg::sample_t    sumIm;
    fftDataPkg::sample_t    diffRe;
    fftDataPkg::sample_t    diffIm;
    fftDataPkg::sample_t    copyRe;
    fftDataPkg::sample_t    copyIm;

    //////////////////////////////////////////////////////////////////////
    // Sequencing
    //////////////////////////////////////////////////////////////////////
    fftControl i_fftControl (
        .clk              (clk),
        .rst              (rst),
        .startF           (startF),
        .startI           (startI),
        .startLoadingRam  (startLoadingRam),
        .loadExternalDone (loadExternalDone),
        .done             (done),
        .outFifoReady     (outFifoReady),
        .outLoadDone      (outLoadDone),
        .calculating      (calculating),
        .loadExternal     (loadExternal),
        .loadInternal     (loadInternal),
        .isIFFT           (isIFFT),
        .loadOutBuffer    (loadOutBuffer),
        .aDone            (aDone),
        .countMode        (countMode)
    );

    fftStepCounter i_fftStepCounter (
        .clk              (clk),
        .rst              (rst),
        .countMode        (countMode),
        .loadExternal     (loadExternal),
        .inValid          (inValid),
        .loadInternal     (loadInternal),
        .loadOutBuffer    (loadOutBuffer),
        .step             (step),
        .loadExternalDone (loadExternalDone),
        .done             (done),
        .outLoadDone      (outLoadDone)
    );

    //////////////////////////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////////////////////////
    sampleRam i_sampleRam (
        .clk          (clk),
        .rst          (rst),
        .loadExternal (loadExternal),
        .inValid      (inValid),
        .inRe         (inRe),
        .inIm         (inIm),
        .loadInternal (loadInternal),
        .step         (step),
        .aRe          (aRe),
        .aIm          (aIm),
        .bRe          (bRe),
        .bIm          (bIm),
        .useTwiddle   (useTwiddle),
        .sumRe        (sumRe),
        .sumIm        (sumIm),
        .diffRe       (diffRe),
        .diffIm       (diffIm),
        .outRe        (copyRe),
        .outIm        (copyIm)
    );

    butterflyUnit i_butterflyUnit (
        .aRe        (aRe),
        .aIm        (aIm),
        .bRe        (bRe),
        .bIm        (bIm),
        .useTwiddle (useTwiddle),
        .isIFFT     (isIFFT),
        .sumRe      (sumRe),
        .sumIm      (sumIm),
        .diffRe     (diffRe),
        .diffIm     (diffIm)
    );

    outBuffer i_outBuffer (
        .clk          (clk),
        .rst          (rst),
        .push         (loadOutBuffer),
        .pushRe       (copyRe),
        .pushIm       (copyIm),
        .outRead      (outRead),
        .outRe        (outRe),
        .outIm        (outIm),
        .outValid     (outValid),
        .outFifoReady (outFifoReady)
    );

endmodule

// ==== logic/outBuffer.sv ====
`include "fft_consts.svh"

module outBuffer (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  fftDataPkg::sample_t pushRe,
    input  fftDataPkg::sample_t pushIm,
    input  logic                outRead,
    output fftDataPkg::sample_t outRe,
    output fftDataPkg::sample_t outIm,
    output logic                outValid,
    output logic                outFifoReady
);

    fftDataPkg::sample_t     bufRe [`FFT_POINTS];
    fftDataPkg::sample_t     bufIm [`FFT_POINTS];
    fftDataPkg::addr_t       wrPtr;
    fftDataPkg::addr_t       rdPtr;
    logic [`ADDR_WIDTH:0]    count;
    logic                    doPush;
    logic                    doPop;

    assign doPush = push && (count != `FFT_POINTS);
    assign doPop  = outRead && (count != '0);

    assign outRe        = bufRe[rdPtr];
    assign outIm        = bufIm[rdPtr];
    assign outValid     = (count != '0);
    assign outFifoReady = (count == '0);

    // Entry storage
    always_ff @(posedge clk) begin
        if (doPush) begin
            bufRe[wrPtr] <= pushRe;
            bufIm[wrPtr] <= pushIm;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= count + doPush - doPop;
        end
    end

endmodule

// ==== logic/butterflyUnit.sv ====
module butterflyUnit (
    input  fftDataPkg::sample_t aRe,
    input  fftDataPkg::sample_t aIm,
    input  fftDataPkg::sample_t bRe,
    input  fftDataPkg::sample_t bIm,
    input  logic                useTwiddle,
    input  logic                isIFFT,
    output fftDataPkg::sample_t sumRe,
    output fftDataPkg::sample_t sumIm,
    output fftDataPkg::sample_t diffRe,
    output fftDataPkg::sample_t diffIm
);

    fftDataPkg::sample_t tRe;
    fftDataPkg::sample_t tIm;

    // b times 1, -j or +j
    always_comb begin
        if (!useTwiddle) begin
            tRe = bRe;
            tIm = bIm;
        end else if (isIFFT) begin
            tRe = -bIm;
            tIm = bRe;
        end else begin
            tRe = bIm;
            tIm = -bRe;
        end
    end

    // Results wrap in sample width
    assign sumRe  = aRe + tRe;
    assign sumIm  = aIm + tIm;
    assign diffRe = aRe - tRe;
    assign diffIm = aIm - tIm;

endmodule

// ==== logic/sampleRam.sv ====
`include "fft_consts.svh"

module sampleRam (
    input  logic                clk,
    input  logic                rst,
    input  logic                loadExternal,
    input  logic                inValid,
    input  fftDataPkg::sample_t inRe,
    input  fftDataPkg::sample_t inIm,
    input  logic                loadInternal,
    input  fftDataPkg::addr_t   step,
    output fftDataPkg::sample_t aRe,
    output fftDataPkg::sample_t aIm,
    output fftDataPkg::sample_t bRe,
    output fftDataPkg::sample_t bIm,
    output logic                useTwiddle,
    input  fftDataPkg::sample_t sumRe,
    input  fftDataPkg::sample_t sumIm,
    input  fftDataPkg::sample_t diffRe,
    input  fftDataPkg::sample_t diffIm,
    output fftDataPkg::sample_t outRe,
    output fftDataPkg::sample_t outIm
);

    fftDataPkg::sample_t memRe [`FFT_POINTS];
    fftDataPkg::sample_t memIm [`FFT_POINTS];
    fftDataPkg::addr_t   loadAddr;
    fftDataPkg::addr_t   aAddr;
    fftDataPkg::addr_t   bAddr;

    // Bit-reversed write order puts the outputs in natural order
    assign loadAddr = {step[0], step[1]};

    //////////////////////////////////////////////////////////////////////
    // Butterfly pair for each step
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (step)
            2'd0: begin aAddr = 2'd0; bAddr = 2'd1; end
            2'd1: begin aAddr = 2'd2; bAddr = 2'd3; end
            2'd2: begin aAddr = 2'd0; bAddr = 2'd2; end
            default: begin aAddr = 2'd1; bAddr = 2'd3; end
        endcase
    end

    // Only the odd pair of the second stage is rotated
    assign useTwiddle = (step == 2'd3);

    assign aRe   = memRe[aAddr];
    assign aIm   = memIm[aAddr];
    assign bRe   = memRe[bAddr];
    assign bIm   = memIm[bAddr];
    assign outRe = memRe[step];
    assign outIm = memIm[step];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `FFT_POINTS; i++) begin
                memRe[i] <= '0;
                memIm[i] <= '0;
            end
        end else if (loadExternal && inValid) begin
            memRe[loadAddr] <= inRe;
            memIm[loadAddr] <= inIm;
        end else if (loadInternal) begin
            memRe[aAddr] <= sumRe;
            memIm[aAddr] <= sumIm;
            memRe[bAddr] <= diffRe;
            memIm[bAddr] <= diffIm;
        end
    end

endmodule

// ==== logic/fftStepCounter.sv ====
`include "fft_consts.svh"

module fftStepCounter (
    input  logic                   clk,
    input  logic                   rst,
    input  fftCtrlPkg::countMode_t countMode,
    input  logic                   loadExternal,
    input  logic                   inValid,
    input  logic                   loadInternal,
    input  logic                   loadOutBuffer,
    output fftDataPkg::addr_t      step,
    output logic                   loadExternalDone,
    output logic                   done,
    output logic                   outLoadDone
);

    localparam fftDataPkg::addr_t LastStep = fftDataPkg::addr_t'(`FFT_POINTS - 1);

    fftDataPkg::addr_t      count;
    fftCtrlPkg::countMode_t lastMode;
    logic                   advance;
    logic                   atLast;

    // A new phase starts from index zero in its very first cycle
    assign step   = (countMode != lastMode) ? '0 : count;
    assign atLast = (step == LastStep);

    always_comb begin
        case (countMode)
            fftCtrlPkg::COUNT_LOAD: advance = loadExternal && inValid;
            fftCtrlPkg::COUNT_CALC: advance = loadInternal;
            fftCtrlPkg::COUNT_OUT:  advance = loadOutBuffer;
            default:                advance = 1'b0;
        endcase
    end

    // End flags of the active phase
    assign loadExternalDone = (countMode == fftCtrlPkg::COUNT_LOAD) && advance && atLast;
    assign done             = (countMode == fftCtrlPkg::COUNT_CALC) && advance && atLast;
    assign outLoadDone      = (countMode == fftCtrlPkg::COUNT_OUT) && advance && atLast;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count    <= '0;
            lastMode <= fftCtrlPkg::COUNT_LOAD;
        end else begin
            lastMode <= countMode;
            count    <= advance ? step + 1'b1 : step;
        end
    end

endmodule

// ==== logic/fftControl.sv ====
module fftControl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   startF,
    input  logic                   startI,
    input  logic                   startLoadingRam,
    input  logic                   loadExternalDone,
    input  logic                   done,
    input  logic                   outFifoReady,
    input  logic                   outLoadDone,
    output logic                   calculating,
    output logic                   loadExternal,
    output logic                   loadInternal,
    output logic                   isIFFT,
    output logic                   loadOutBuffer,
    output logic                   aDone,
    output fftCtrlPkg::countMode_t countMode
);

    fftCtrlPkg::state_t state;
    fftCtrlPkg::state_t nextState;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= fftCtrlPkg::IDLE;
        end else begin
            state <= nextState;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Next state and outputs
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        nextState     = state;
        calculating   = 1'b1;
        loadExternal  = 1'b0;
        loadInternal  = 1'b0;
        isIFFT        = 1'b0;
        loadOutBuffer = 1'b0;
        aDone         = 1'b0;
        countMode     = fftCtrlPkg::COUNT_LOAD;

        case (state)
            fftCtrlPkg::IDLE: begin
                calculating = 1'b0;
                // Forward wins when both strobes arrive together
                if (startF) begin
                    nextState = fftCtrlPkg::IDLE_LOADF;
                end else if (startI) begin
                    nextState = fftCtrlPkg::IDLE_LOADI;
                end
            end

            // Wait for the source to begin streaming samples
            fftCtrlPkg::IDLE_LOADF: begin
                if (startLoadingRam) begin
                    nextState = fftCtrlPkg::LOADF;
                end
            end
            fftCtrlPkg::IDLE_LOADI: begin
                if (startLoadingRam) begin
                    nextState = fftCtrlPkg::LOADI;
                end
            end

            fftCtrlPkg::LOADF: begin
                loadExternal = 1'b1;
                if (loadExternalDone) begin
                    nextState = fftCtrlPkg::CALCULATINGF;
                end
            end
            fftCtrlPkg::LOADI: begin
                loadExternal = 1'b1;
                if (loadExternalDone) begin
                    nextState = fftCtrlPkg::CALCULATINGI;
                end
            end

            // Done comes with the last of the four butterflies
            fftCtrlPkg::CALCULATINGF: begin
                countMode    = fftCtrlPkg::COUNT_CALC;
                loadInternal = 1'b1;
                if (done) begin
                    nextState = fftCtrlPkg::LOADOUT;
                end
            end
            fftCtrlPkg::CALCULATINGI: begin
                countMode    = fftCtrlPkg::COUNT_CALC;
                loadInternal = 1'b1;
                isIFFT       = 1'b1;
                if (done) begin
                    nextState = fftCtrlPkg::LOADOUT;
                end
            end

            // Hold until the previous results have been read out
            fftCtrlPkg::LOADOUT: begin
                countMode = fftCtrlPkg::COUNT_OUT;
                if (outFifoReady) begin
                    nextState = fftCtrlPkg::IDLE_LOADOUT;
                end
            end

            fftCtrlPkg::IDLE_LOADOUT: begin
                countMode     = fftCtrlPkg::COUNT_OUT;
                loadOutBuffer = 1'b1;
                if (outLoadDone) begin
                    nextState = fftCtrlPkg::DONE;
                end
            end

            fftCtrlPkg::DONE: begin
                countMode = fftCtrlPkg::COUNT_OUT;
                aDone     = 1'b1;
                nextState = fftCtrlPkg::IDLE;
            end

            default: begin
                calculating = 1'b0;
                nextState   = fftCtrlPkg::IDLE;
            end
        endcase
    end

endmodule

// ==== logic/fftCtrlPkg.sv ====
package fftCtrlPkg;

    // Controller sequence
    typedef enum logic [3:0] {
        IDLE,
        IDLE_LOADI,
        IDLE_LOADF,
        LOADI,
        LOADF,
        CALCULATINGI,
        CALCULATINGF,
        LOADOUT,
        IDLE_LOADOUT,
        DONE
    } state_t;

    // Which phase the step counter is following
    typedef enum logic [1:0] {
        COUNT_LOAD,
        COUNT_CALC,
        COUNT_OUT
    } countMode_t;

endpackage

// ==== logic/fftDataPkg.sv ====
`include "fft_consts.svh"

package fftDataPkg;

    // One signed real or imaginary part
    typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;

    // Word index into the sample store or the output buffer
    typedef logic [`ADDR_WIDTH-1:0] addr_t;

endpackage

// ==== logic/fft_consts.svh ====
`ifndef FFT_CONSTS_SVH
`define FFT_CONSTS_SVH

// Transform length in complex points
`define FFT_POINTS 4

// Width of one real or imaginary part
`define SAMPLE_WIDTH 16

// Index width for the store and the result buffer
`define ADDR_WIDTH 2

`endif
